/* design/urf_sense_pkg.sv */
// Sensor timing constants, ranger state encoding and result record shared by the ranging blocks
package urf_sense_pkg;

    // Trigger pulse width in us-cycles, HC-SR04 wants at least 10 us
    parameter int TRIG_US = 10;

    // 2^16 / 58 rounded, one multiply turns echo time into centimetres
    parameter int unsigned RECIP_58 = 1130;

    parameter int TIME_W  = 18;  // Period and timer width, covers 80 ms
    parameter int RANGE_W = 10;  // Up to 1023 cm, sensor tops out near 400

    // Ranger FSM
    typedef enum logic [2:0] {
        IDLE,     // Disabled
        TRIGGER,  // Trigger pin high
        LISTEN,   // Echo window open
        CONVERT,  // Time to range
        WAIT      // Until next period wrap
    } ranger_state_t;

    // One measurement, 28 bits
    typedef struct packed {
        logic [RANGE_W-1:0] range_cm;   // Distance in cm
        logic [15:0]        echo_us;    // Raw echo high time
        logic               echo_err;   // Echo already high at trigger
        logic               overrange;  // Echo still high at window end
    } urf_result_t;

endpackage

/* design/urf_reg_pkg.sv */
// Register map and request/response records of the ranger control port
package urf_reg_pkg;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } reg_op_t;

    // Register addresses, 5 to 7 are unused and answer with err
    typedef enum logic [2:0] {
        ADDR_CTRL   = 3'd0,  // Bit 0 enable
        ADDR_PERIOD = 3'd1,  // Repeat period in us
        ADDR_ALARM  = 3'd2,  // Alarm threshold in cm
        ADDR_STATUS = 3'd3,  // Alarm, busy, drop count; write clears drops
        ADDR_LAST   = 3'd4   // Last result record
    } reg_addr_t;

    typedef struct packed {
        reg_op_t     op;
        reg_addr_t   addr;
        logic [31:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;    // Bad address
    } reg_resp_t;

endpackage

/* design/urf_echo_sync.sv */
// Brings the asynchronous echo pin into the us_clk domain and strips single-cycle glitches
`timescale 1ns/1ns

module urf_echo_sync (
    input  logic us_clk,
    input  logic resetn,
    input  logic echo_in,
    output logic echo_clean
);

    logic sync1;  // Metastability stage
    logic sync2;  // Settled sample

    // Filter stage only follows when the two newest samples agree,
    // so both edges see the same 3-cycle delay
    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            sync1      <= 1'b0;
            sync2      <= 1'b0;
            echo_clean <= 1'b0;
        end else begin
            sync1 <= echo_in;
            sync2 <= sync1;
            if (sync1 == sync2) begin
                echo_clean <= sync2;  // Stable for two samples
            end
        end
    end

    // Any run on the filtered echo is at least two cycles long
    a_min_run: assert property (@(posedge us_clk) disable iff (!resetn)
        $changed(echo_clean) |=> $stable(echo_clean))
        else $error("echo_clean run shorter than 2 cycles");

endmodule

/* design/urf_ranger.sv */
// Ranging engine: fires the trigger, times the echo and converts it to a range once per period
`timescale 1ns/1ns

module urf_ranger #(
    parameter int ECHO_WINDOW = 23257  // (58 * 401) - 1 us, just past max range
) (
    input  logic                              us_clk,
    input  logic                              resetn,
    input  logic                              echo_clean,
    input  logic                              enable,
    input  logic [urf_sense_pkg::TIME_W-1:0]  period,
    output logic                              trigger_out,
    output logic                              busy,
    output logic                              result_valid,
    output urf_sense_pkg::urf_result_t        result
);

    urf_sense_pkg::ranger_state_t             state;
    logic [urf_sense_pkg::TIME_W-1:0]         per_cnt;     // Period counter
    logic [urf_sense_pkg::TIME_W-1:0]         tmr;         // Cycles in current state
    logic [urf_sense_pkg::TIME_W-1:0]         echo_cnt;    // Echo high cycles
    logic                                     echo_err;
    logic                                     overrange;
    logic [urf_sense_pkg::RANGE_W-1:0]        last_range;  // Last good range
    logic [31:0]                              product;
    logic [urf_sense_pkg::RANGE_W-1:0]        calc_range;
    logic                                     wrap;
    logic                                     start;

    assign wrap  = per_cnt == period - 1'b1;
    assign start = enable && (state == urf_sense_pkg::IDLE ||
                              (state == urf_sense_pkg::WAIT && wrap));
    assign busy  = state != urf_sense_pkg::IDLE && state != urf_sense_pkg::WAIT;

    // us * 1130 / 65536 ~= us / 58
    assign product    = 32'(echo_cnt) * urf_sense_pkg::RECIP_58;
    assign calc_range = product[16 +: urf_sense_pkg::RANGE_W];

    // Held at zero while idle so the first trigger lines up with count 0
    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            per_cnt <= '0;
        end else if (state == urf_sense_pkg::IDLE || wrap) begin
            per_cnt <= '0;
        end else begin
            per_cnt <= per_cnt + 1'b1;
        end
    end

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            state        <= urf_sense_pkg::IDLE;
            tmr          <= '0;
            echo_cnt     <= '0;
            echo_err     <= 1'b0;
            overrange    <= 1'b0;
            trigger_out  <= 1'b0;
            result_valid <= 1'b0;
            last_range   <= '0;
        end else begin
            result_valid <= 1'b0;        // Single-cycle push
            tmr          <= tmr + 1'b1;
            case (state)
                urf_sense_pkg::IDLE, urf_sense_pkg::WAIT: begin
                    if (start) begin
                        state       <= urf_sense_pkg::TRIGGER;
                        tmr         <= '0;
                        echo_cnt    <= '0;
                        overrange   <= 1'b0;
                        trigger_out <= 1'b1;
                    end else if (!enable) begin
                        state <= urf_sense_pkg::IDLE;  // Stop after finished measurement
                    end
                end
                urf_sense_pkg::TRIGGER: begin
                    if (tmr == '0) begin
                        echo_err <= echo_clean;        // Sensor still busy from before
                    end
                    if (int'(tmr) == urf_sense_pkg::TRIG_US - 1) begin
                        state       <= urf_sense_pkg::LISTEN;
                        tmr         <= '0;
                        trigger_out <= 1'b0;
                    end
                end
                urf_sense_pkg::LISTEN: begin
                    if (echo_clean) begin
                        echo_cnt <= echo_cnt + 1'b1;
                    end
                    if (int'(tmr) == ECHO_WINDOW - 1) begin
                        overrange <= echo_clean;       // Echo outlived the window
                        state     <= urf_sense_pkg::CONVERT;
                    end
                end
                urf_sense_pkg::CONVERT: begin
                    state        <= urf_sense_pkg::WAIT;
                    result_valid <= 1'b1;
                    if (!echo_err && !overrange) begin
                        last_range <= calc_range;
                    end
                end
                default: state <= urf_sense_pkg::IDLE;
            endcase
        end
    end

    // Result record, qualified by result_valid
    always_ff @(posedge us_clk) begin
        if (state == urf_sense_pkg::CONVERT) begin
            result.range_cm  <= echo_err ? last_range : calc_range;  // Repeat on error
            result.echo_us   <= echo_cnt[15:0];
            result.echo_err  <= echo_err;
            result.overrange <= overrange;
        end
    end

    a_trig_state: assert property (@(posedge us_clk) disable iff (!resetn)
        trigger_out |-> state == urf_sense_pkg::TRIGGER)
        else $error("trigger_out high outside TRIGGER");

    a_valid_pulse: assert property (@(posedge us_clk) disable iff (!resetn)
        result_valid |=> !result_valid)
        else $error("result_valid longer than one cycle");

endmodule

/* design/urf_regs.sv */
// Control and status registers of the ranger, with alarm compare and the request/response port
`timescale 1ns/1ns

module urf_regs #(
    parameter int PERIOD_RESET = 80000  // 80 ms between measurements
) (
    input  logic                              us_clk,
    input  logic                              resetn,
    input  logic                              req_valid,
    output logic                              req_ready,
    input  urf_reg_pkg::reg_req_t             req,
    output logic                              resp_valid,
    input  logic                              resp_ready,
    output urf_reg_pkg::reg_resp_t            resp,
    input  logic                              busy,
    input  logic                              result_valid,
    input  urf_sense_pkg::urf_result_t        result,
    input  logic [7:0]                        drop_count,
    output logic                              enable,
    output logic [urf_sense_pkg::TIME_W-1:0]  period,
    output logic                              drop_clear,
    output logic                              alarm
);

    logic [urf_sense_pkg::RANGE_W-1:0] alarm_thr;
    urf_sense_pkg::urf_result_t        last_res;
    logic [31:0]                       rd_data;
    logic                              rd_err;
    logic                              req_take;  // Request accepted this cycle
    logic                              wr_en;
    logic                              below;

    assign req_ready  = !resp_valid;             // One outstanding response
    assign req_take   = req_valid && req_ready;
    assign wr_en      = req_take && req.op == urf_reg_pkg::OP_WRITE;
    assign drop_clear = wr_en && req.addr == urf_reg_pkg::ADDR_STATUS;
    assign below      = result.range_cm < alarm_thr;

    // Read mux, also returned on writes
    always_comb begin
        rd_data = '0;
        rd_err  = 1'b0;
        case (req.addr)
            urf_reg_pkg::ADDR_CTRL:   rd_data = 32'(enable);
            urf_reg_pkg::ADDR_PERIOD: rd_data = 32'(period);
            urf_reg_pkg::ADDR_ALARM:  rd_data = 32'(alarm_thr);
            urf_reg_pkg::ADDR_STATUS: rd_data = {16'b0, drop_count, 6'b0, busy, alarm};
            urf_reg_pkg::ADDR_LAST:   rd_data = 32'(last_res);
            default:                  rd_err  = 1'b1;
        endcase
    end

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            enable    <= 1'b0;
            period    <= PERIOD_RESET[urf_sense_pkg::TIME_W-1:0];
            alarm_thr <= '0;                     // Alarm never fires until set
        end else if (wr_en) begin
            case (req.addr)
                urf_reg_pkg::ADDR_CTRL:   enable    <= req.wdata[0];
                urf_reg_pkg::ADDR_PERIOD: period    <= req.wdata[urf_sense_pkg::TIME_W-1:0];
                urf_reg_pkg::ADDR_ALARM:  alarm_thr <= req.wdata[urf_sense_pkg::RANGE_W-1:0];
                default: ;                        // STATUS clears via drop_clear, LAST is RO
            endcase
        end
    end

    // Alarm sets only on a clean near result, any far result clears it
    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            last_res <= '0;
            alarm    <= 1'b0;
        end else if (result_valid) begin
            last_res <= result;
            if (!below) begin
                alarm <= 1'b0;
            end else if (!result.echo_err && !result.overrange) begin
                alarm <= 1'b1;
            end
        end
    end

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            resp_valid <= 1'b0;
        end else if (req_take) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge us_clk) begin
        if (req_take) begin
            resp.rdata <= rd_data;
            resp.err   <= rd_err;
        end
    end

    a_resp_hold: assert property (@(posedge us_clk) disable iff (!resetn)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else $error("response changed before it was taken");

endmodule

/* design/urf_result_queue.sv */
// Small FIFO between the ranger and the result stream; overflowing results are dropped and counted
`timescale 1ns/1ns

module urf_result_queue #(
    parameter int QUEUE_DEPTH = 4  // Power of two
) (
    input  logic                       us_clk,
    input  logic                       resetn,
    input  logic                       push,
    input  urf_sense_pkg::urf_result_t push_data,
    output logic                       res_valid,
    input  logic                       res_ready,
    output urf_sense_pkg::urf_result_t res,
    input  logic                       drop_clear,
    output logic [7:0]                 drop_count
);

    localparam int AW = $clog2(QUEUE_DEPTH);

    urf_sense_pkg::urf_result_t mem [QUEUE_DEPTH];
    logic [AW-1:0]              wr_ptr;
    logic [AW-1:0]              rd_ptr;
    logic [AW:0]                count;   // Occupancy, 0..QUEUE_DEPTH
    logic                       full;
    logic                       wr;
    logic                       pop;

    assign full      = int'(count) == QUEUE_DEPTH;
    assign wr        = push && !full;    // Overflow drops the new item
    assign pop       = res_valid && res_ready;
    assign res_valid = count != '0;
    assign res       = mem[rd_ptr];      // Head stays put until popped

    always_ff @(posedge us_clk) begin
        if (wr) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            drop_count <= '0;
        end else begin
            if (wr) wr_ptr <= wr_ptr + 1'b1;   // Natural wrap
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({wr, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (drop_clear) begin
                drop_count <= '0;
            end else if (push && full && drop_count != 8'hFF) begin
                drop_count <= drop_count + 1'b1;  // Saturates at 255
            end
        end
    end

    a_no_overfill: assert property (@(posedge us_clk) disable iff (!resetn)
        int'(count) <= QUEUE_DEPTH)
        else $error("queue occupancy above depth");

endmodule

/* design/urf_subsystem.sv */
// Top of the ultrasonic ranging subsystem; wires sync, ranger, registers and result queue together
`timescale 1ns/1ns

module urf_subsystem #(
    parameter int ECHO_WINDOW  = 23257,
    parameter int QUEUE_DEPTH  = 4,
    parameter int PERIOD_RESET = 80000
) (
    input  logic                       us_clk,        // 1 MHz, one cycle per us
    input  logic                       resetn,
    input  logic                       echo_in,       // Raw sensor pin
    output logic                       trigger_out,
    input  logic                       req_valid,
    output logic                       req_ready,
    input  urf_reg_pkg::reg_req_t      req,
    output logic                       resp_valid,
    input  logic                       resp_ready,
    output urf_reg_pkg::reg_resp_t     resp,
    output logic                       res_valid,
    input  logic                       res_ready,
    output urf_sense_pkg::urf_result_t res,
    output logic                       alarm          // Level, not an interrupt
);

    logic                              echo_clean;
    logic                              enable;
    logic [urf_sense_pkg::TIME_W-1:0]  period;
    logic                              busy;
    logic                              result_valid;
    urf_sense_pkg::urf_result_t        result;
    logic [7:0]                        drop_count;
    logic                              drop_clear;

    urf_echo_sync u_sync (
        .us_clk, .resetn, .echo_in, .echo_clean
    );

    urf_ranger #(.ECHO_WINDOW(ECHO_WINDOW)) u_ranger (
        .us_clk, .resetn, .echo_clean, .enable, .period,
        .trigger_out, .busy, .result_valid, .result
    );

    urf_regs #(.PERIOD_RESET(PERIOD_RESET)) u_regs (
        .us_clk, .resetn, .req_valid, .req_ready, .req,
        .resp_valid, .resp_ready, .resp, .busy, .result_valid, .result,
        .drop_count, .enable, .period, .drop_clear, .alarm
    );

    urf_result_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .us_clk, .resetn,
        .push      (result_valid),
        .push_data (result),
        .res_valid, .res_ready, .res, .drop_clear, .drop_count
    );

endmodule

/* testbench/urf_echo_model.sv */
// Behavioral ultrasonic sensor for the testbench, answers each trigger with a programmed echo pulse
`timescale 1ns/1ns

module urf_echo_model (
    input  logic us_clk,
    input  logic trigger,     // From the DUT trigger pin
    input  int   delay_us,    // Gap between trigger fall and echo rise
    input  int   width_us,    // Echo high time
    input  logic glitches,    // Add a one-cycle dip and a one-cycle spike
    input  logic hold_high,   // Force echo high regardless of trigger
    output logic echo
);

    logic pulse;  // Echo from the trigger response alone

    assign echo = pulse | hold_high;

    initial begin
        pulse = 1'b0;
        forever begin
            @(negedge trigger);
            repeat (delay_us) @(posedge us_clk);
            #2;
            // One sample per cycle, so the pin is high for width_us edges
            for (int i = 0; i < width_us; i++) begin
                pulse = !(glitches && i == width_us / 2);  // Dip in the middle
                @(posedge us_clk);
                #2;
            end
            pulse = 1'b0;
            if (glitches) begin
                repeat (4) @(posedge us_clk);
                #2 pulse = 1'b1;   // Lone spike after the echo
                @(posedge us_clk);
                #2 pulse = 1'b0;
            end
        end
    end

endmodule

/* testbench/tb_urf_subsystem.sv */
// Directed testbench for the ranging subsystem, run through urf_subsystem.f and run_sim.sh
`timescale 1ns/1ns

module tb_urf_subsystem;

    localparam int PERIOD_US      = 600;
    localparam int TIMEOUT_CYCLES = 20 * PERIOD_US;  // All tests fit in about 15 periods

    logic                       us_clk;
    logic                       resetn;
    logic                       echo_in;
    logic                       trigger_out;
    logic                       req_valid;
    logic                       req_ready;
    urf_reg_pkg::reg_req_t      req;
    logic                       resp_valid;
    logic                       resp_ready;
    urf_reg_pkg::reg_resp_t     resp;
    logic                       res_valid;
    logic                       res_ready;
    urf_sense_pkg::urf_result_t res;
    logic                       alarm;

    // Echo model controls
    int   delay_us;
    int   width_us;
    logic glitches;
    logic hold_high;

    int errors;
    int cycles;
    int trig_run;       // Current trigger high run
    int last_trig_len;  // Length of the last complete trigger pulse
    int good_range;     // Last clean range the testbench expects

    urf_subsystem #(.ECHO_WINDOW(400), .PERIOD_RESET(PERIOD_US)) DUT (
        .us_clk, .resetn, .echo_in, .trigger_out,
        .req_valid, .req_ready, .req, .resp_valid, .resp_ready, .resp,
        .res_valid, .res_ready, .res, .alarm
    );

    urf_echo_model sensor (
        .us_clk, .trigger(trigger_out), .delay_us, .width_us,
        .glitches, .hold_high, .echo(echo_in)
    );

    initial begin
        us_clk = 1'b0;
        forever #10 us_clk = !us_clk;
    end

    // Trigger width monitor and run limit
    always @(posedge us_clk) begin
        cycles = cycles + 1;
        if (trigger_out) begin
            trig_run = trig_run + 1;
        end else if (trig_run != 0) begin
            last_trig_len = trig_run;
            trig_run      = 0;
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: DUT did not answer within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors: %0d", errors);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic int range_of(input int us);
        return (us * 1130) >> 16;  // Reciprocal of 58 with 16 fraction bits
    endfunction

    task automatic check_eq(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            errors++;
            $display("ERR %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // One register transaction, resp_ready is held high
    task automatic reg_access(input logic wr, input logic [2:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(posedge us_clk);
        #2;
        req_valid  = 1'b1;
        req.op     = wr ? urf_reg_pkg::OP_WRITE : urf_reg_pkg::OP_READ;
        req.addr   = urf_reg_pkg::reg_addr_t'(addr);
        req.wdata  = wdata;
        @(posedge us_clk);
        while (!req_ready) @(posedge us_clk);
        #2 req_valid = 1'b0;
        @(posedge us_clk);
        while (!resp_valid) @(posedge us_clk);
        rdata = resp.rdata;
        err   = resp.err;
    endtask

    task automatic reg_write(input logic [2:0] addr, input logic [31:0] wdata);
        logic [31:0] rd;
        logic        err;
        reg_access(1'b1, addr, wdata, rd, err);
    endtask

    task automatic reg_read(input logic [2:0] addr, output logic [31:0] rdata,
                            output logic err);
        reg_access(1'b0, addr, 32'b0, rdata, err);
    endtask

    // Waits for the next result taken from the stream
    task automatic get_result(output urf_sense_pkg::urf_result_t r);
        @(posedge us_clk);
        while (!(res_valid && res_ready)) @(posedge us_clk);
        r = res;
    endtask

    task automatic wait_push();
        @(posedge us_clk);
        while (!DUT.u_ranger.result_valid) @(posedge us_clk);
    endtask

    task automatic reg_readback();
        logic [31:0] rd;
        logic        err;
        reg_write(3'd1, 32'd777);
        reg_read(3'd1, rd, err);
        check_eq("reg_access period", 777, int'(rd));
        reg_write(3'd1, PERIOD_US);                    // Back to test period
        reg_write(3'd2, 32'h155);
        reg_read(3'd2, rd, err);
        check_eq("reg_access alarm", 32'h155, int'(rd));
        reg_write(3'd2, 32'd0);
        reg_read(3'd6, rd, err);
        check_eq("reg_access bad addr err", 1, int'(err));
        reg_read(3'd3, rd, err);
        check_eq("reg_access drop count", 0, int'(rd[15:8]));
    endtask

    task automatic single_range();
        urf_sense_pkg::urf_result_t r;
        int          w;
        logic [31:0] rd;
        logic        err;
        for (int i = 0; i < 5; i++) begin
            w = 20 + int'($urandom % 331);
            width_us = w;
            if (i == 0) begin
                reg_write(3'd0, 32'd1);                // Enable starts a measurement
                reg_read(3'd3, rd, err);               // Lands in TRIGGER
                check_eq("single_range busy", 1, int'(rd[1]));
            end
            get_result(r);
            check_eq("single_range echo_us", w, int'(r.echo_us));
            check_eq("single_range range_cm", range_of(w), int'(r.range_cm));
            check_eq("single_range echo_err", 0, int'(r.echo_err));
            check_eq("single_range overrange", 0, int'(r.overrange));
            check_eq("single_range trigger width", 10, last_trig_len);
            good_range = range_of(w);
        end
    endtask

    task automatic echo_error();
        urf_sense_pkg::urf_result_t r;
        #2 hold_high = 1'b1;                          // Echo already high at trigger
        get_result(r);
        #2 hold_high = 1'b0;
        check_eq("echo_error flag", 1, int'(r.echo_err));
        check_eq("echo_error range_cm", good_range, int'(r.range_cm));
    endtask

    task automatic overrange();
        urf_sense_pkg::urf_result_t r;
        width_us = 500;                               // Outlives the 400 us window
        get_result(r);
        check_eq("overrange flag", 1, int'(r.overrange));
        check_eq("overrange echo_err", 0, int'(r.echo_err));
    endtask

    task automatic backpressure();
        urf_sense_pkg::urf_result_t r;
        int          widths[6];
        logic [31:0] rd;
        logic        err;
        #2 res_ready = 1'b0;
        for (int i = 0; i < 6; i++) begin
            widths[i] = 20 + int'($urandom % 331);
            width_us  = widths[i];
            wait_push();
        end
        reg_write(3'd0, 32'd0);                       // Stop before the next period
        reg_read(3'd3, rd, err);
        check_eq("backpressure drop count", 2, int'(rd[15:8]));
        @(posedge us_clk);
        #2 res_ready = 1'b1;
        for (int i = 0; i < 4; i++) begin
            get_result(r);
            check_eq("backpressure order", widths[i], int'(r.echo_us));
        end
        @(posedge us_clk);
        check_eq("backpressure empty", 0, int'(res_valid));
        reg_write(3'd3, 32'd0);                       // Clears drop count
        reg_read(3'd3, rd, err);
        check_eq("backpressure drop clear", 0, int'(rd[15:8]));
    endtask

    task automatic glitch_alarm();
        urf_sense_pkg::urf_result_t r;
        logic [31:0] rd;
        logic        err;
        reg_write(3'd2, range_of(100) + 1);
        width_us = 100;
        glitches = 1'b1;
        reg_write(3'd0, 32'd1);
        get_result(r);
        check_eq("glitch_alarm echo_us", 100, int'(r.echo_us));
        check_eq("glitch_alarm range_cm", range_of(100), int'(r.range_cm));
        check_eq("glitch_alarm alarm high", 1, int'(alarm));
        reg_read(3'd3, rd, err);
        check_eq("glitch_alarm status alarm", 1, int'(rd[0]));
        glitches = 1'b0;
        width_us = 300;                               // Range at or above threshold
        get_result(r);
        check_eq("glitch_alarm far echo_us", 300, int'(r.echo_us));
        check_eq("glitch_alarm alarm low", 0, int'(alarm));
    endtask

    initial begin
        void'($urandom(32'h8a1e_127d));
        errors        = 0;
        cycles        = 0;
        trig_run      = 0;
        last_trig_len = 0;
        good_range    = 0;
        delay_us      = 5;
        width_us      = 100;
        glitches      = 1'b0;
        hold_high     = 1'b0;
        resetn        = 1'b0;
        req_valid     = 1'b0;
        req           = '0;
        resp_ready    = 1'b1;
        res_ready     = 1'b1;
        repeat (3) @(posedge us_clk);
        #2 resetn = 1'b1;
        check_eq("reset alarm", 0, int'(alarm));
        check_eq("reset res_valid", 0, int'(res_valid));
        reg_readback();
        single_range();
        echo_error();
        overrange();
        backpressure();
        glitch_alarm();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* urf_subsystem.f */
design/urf_sense_pkg.sv
design/urf_reg_pkg.sv
design/urf_echo_sync.sv
design/urf_ranger.sv
design/urf_regs.sv
design/urf_result_queue.sv
design/urf_subsystem.sv
testbench/urf_echo_model.sv
testbench/tb_urf_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the ranging subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_urf_subsystem \
    -f urf_subsystem.f

out=$(./obj_dir/Vtb_urf_subsystem)
echo "$out"

if grep -q "Test OK" <<< "$out"; then
    exit 0
else
    exit 1
fi
